// File: sources.f
verilog/trdb_pkg.sv
verilog/trdb_lzc.sv
verilog/trdb_addr_compress.sv
verilog/trdb_packet_select.sv
verilog/trdb_priority.sv
bench/trdb_priority_checker.sv
bench/trdb_priority_tb.sv

// File: run.sh
#!/bin/sh
# Verilator build and run of the packet-selection testbench

cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found"
    exit 1
fi

verilator --binary --timing --assert \
    -f sources.f \
    --top-module trdb_priority_tb \
    -o trdb_priority_sim
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$(./obj_dir/trdb_priority_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'All tests passed!'; then
    exit 0
fi
echo "simulation did not pass"
exit 1

// File: bench/trdb_priority_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the packet-selection stage
// directed tests, random run, reference model and timeout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module trdb_priority_tb import trdb_pkg::*; ();

    // random run length plus directed cycles and margin
    localparam int RAND_CYCLES = 2000;
    localparam int MAX_CYCLES  = 3000;

    logic clk_i, rst_ni, valid_i;
    logic lc_exception_i, lc_updiscon_i, lc_final_qualified_i;
    logic tc_qualified_i, tc_exception_i, tc_retired_i, tc_first_qualified_i;
    logic tc_privchange_i, tc_gt_max_resync_i, tc_et_max_resync_i;
    logic tc_branch_map_empty_i, tc_branch_map_full_i;
    logic tc_enc_enabled_i, tc_enc_disabled_i, tc_opmode_change_i;
    logic nc_exception_i, nc_privchange_i, nc_branch_map_empty_i;
    logic nc_qualified_i, nc_retired_i;
    addr_t addr_to_compress_i;
    logic valid_o, thaddr_o, lc_tc_mux_o, resync_timer_rst_o;
    trdb_format_e packet_format_o;
    trdb_f_sync_subformat_e packet_f_sync_subformat_o;
    qual_status_e qual_status_o;
    keep_bits_t keep_bits_o;

    // expected outputs and model history
    logic exp_valid, exp_thaddr, exp_mux, exp_rst;
    trdb_format_e exp_format;
    trdb_f_sync_subformat_e exp_sub;
    qual_status_e exp_qual;
    keep_bits_t exp_keep;
    logic m_reported, m_ntr, m_rep;
    logic nxt_reported, nxt_ntr, nxt_rep;

    logic [31:0] lfsr_q = 32'hb994_83da;
    string test_name = "reset";
    int err_count = 0;
    int test_mark = 0;
    int pass_tests = 0;
    int fail_tests = 0;
    int cycles = 0;

    trdb_priority DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    // galois lfsr, one step per bit
    function automatic logic rand_bit();
        logic b;
        b = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (b) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_word(input int n);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < n; i++) begin
            w = {w[30:0], rand_bit()};
        end
        return w;
    endfunction

    // expected outputs and next history from the flowchart
    function automatic void predict();
        logic tc_exc_only;
        logic rep_val;
        trdb_format_e map_fmt;
        int lead;
        logic run;
        tc_exc_only = tc_exception_i && !tc_retired_i;
        map_fmt = tc_branch_map_empty_i ? F_ADDR_ONLY : F_DIFF_DELTA;
        exp_valid = 1'b0;
        exp_format = F_OPT_EXT;
        exp_sub = SF_START;
        exp_thaddr = 1'b0;
        exp_mux = 1'b0;
        exp_rst = 1'b0;
        exp_qual = NO_CHANGE;
        rep_val = 1'b0;
        nxt_ntr = 1'b0;
        nxt_rep = 1'b0;
        if (!valid_i) begin
            // nothing emitted
        end else if (tc_enc_enabled_i || tc_enc_disabled_i || tc_opmode_change_i
                     || lc_final_qualified_i) begin
            exp_valid = 1'b1;
            exp_format = F_SYNC;
            exp_sub = SF_SUPPORT;
            exp_qual = m_ntr ? ENDED_NTR : (m_rep ? ENDED_REP : NO_CHANGE);
        end else if (tc_qualified_i) begin
            if (lc_exception_i) begin
                exp_valid = 1'b1;
                exp_format = F_SYNC;
                exp_rst = 1'b1;
                if (tc_exc_only) begin
                    exp_sub = SF_TRAP;
                    rep_val = 1'b1;
                end else if (m_reported) begin
                    exp_sub = SF_START;
                end else begin
                    exp_sub = SF_TRAP;
                    exp_thaddr = 1'b1;
                end
            end else if (tc_first_qualified_i || tc_privchange_i || tc_gt_max_resync_i) begin
                exp_valid = 1'b1;
                exp_format = F_SYNC;
                exp_rst = 1'b1;
            end else if (lc_updiscon_i) begin
                exp_valid = 1'b1;
                nxt_ntr = 1'b1;
                exp_format = map_fmt;
                if (tc_exc_only) begin
                    exp_format = F_SYNC;
                    exp_sub = SF_TRAP;
                    exp_mux = 1'b1;
                    exp_rst = 1'b1;
                end
            end else if ((tc_et_max_resync_i && !tc_branch_map_empty_i)
                         || (tc_exception_i && tc_retired_i)) begin
                exp_valid = 1'b1;
                exp_format = map_fmt;
            end else if ((nc_exception_i && !nc_retired_i)
                         || (nc_privchange_i && !nc_branch_map_empty_i) || !nc_qualified_i) begin
                exp_valid = 1'b1;
                exp_format = map_fmt;
                nxt_rep = !nc_qualified_i;
            end else if (tc_branch_map_full_i) begin
                exp_valid = 1'b1;
                exp_format = F_DIFF_DELTA;
            end
        end
        nxt_reported = m_reported;
        if (exp_format == F_SYNC && ((exp_sub == SF_TRAP && !exp_thaddr)
                                     || (exp_sub == SF_START && !tc_exc_only))) begin
            nxt_reported = rep_val;
        end
        // leading run of the sign bit
        lead = 0;
        run = 1'b1;
        for (int i = XLEN - 1; i >= 0; i--) begin
            if (run && addr_to_compress_i[i] == addr_to_compress_i[XLEN-1]) begin
                lead++;
            end else begin
                run = 1'b0;
            end
        end
        exp_keep = (lead == XLEN) ? keep_bits_t'(1) : keep_bits_t'(XLEN - lead + 1);
    endfunction

    task automatic mismatch(input string field, input int expv, input int actv);
        err_count++;
        $display("FAILED %s: %s expected %0d actual %0d", test_name, field, expv, actv);
    endtask

    // compare late in the low phase, then advance the model history
    always @(negedge clk_i) begin
        #3;
        if (!rst_ni) begin
            m_reported = 1'b0;
            m_ntr = 1'b0;
            m_rep = 1'b0;
        end else begin
            predict();
            if (valid_o !== exp_valid) mismatch("valid_o", int'(exp_valid), int'(valid_o));
            if (packet_format_o !== exp_format)
                mismatch("format", int'(exp_format), int'(packet_format_o));
            if (packet_f_sync_subformat_o !== exp_sub)
                mismatch("subformat", int'(exp_sub), int'(packet_f_sync_subformat_o));
            if (thaddr_o !== exp_thaddr) mismatch("thaddr_o", int'(exp_thaddr), int'(thaddr_o));
            if (lc_tc_mux_o !== exp_mux) mismatch("lc_tc_mux_o", int'(exp_mux), int'(lc_tc_mux_o));
            if (resync_timer_rst_o !== exp_rst)
                mismatch("resync_timer_rst_o", int'(exp_rst), int'(resync_timer_rst_o));
            if (qual_status_o !== exp_qual)
                mismatch("qual_status_o", int'(exp_qual), int'(qual_status_o));
            if (keep_bits_o !== exp_keep)
                mismatch("keep_bits_o", int'(exp_keep), int'(keep_bits_o));
            m_reported = nxt_reported;
            m_ntr = nxt_ntr;
            m_rep = nxt_rep;
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped: cycle limit of %0d reached in test %s", MAX_CYCLES, test_name);
            $display("Test failures found");
            $finish;
        end
    end

    // all conditions quiet, next instruction qualified
    task automatic drive_idle();
        {valid_i, lc_exception_i, lc_updiscon_i, lc_final_qualified_i} = '0;
        {tc_qualified_i, tc_exception_i, tc_retired_i, tc_first_qualified_i} = '0;
        {tc_privchange_i, tc_gt_max_resync_i, tc_et_max_resync_i} = '0;
        {tc_branch_map_empty_i, tc_branch_map_full_i, tc_enc_enabled_i} = '0;
        {tc_enc_disabled_i, tc_opmode_change_i, nc_exception_i, nc_privchange_i} = '0;
        {nc_branch_map_empty_i, nc_retired_i} = '0;
        nc_qualified_i = 1'b1;
        addr_to_compress_i = '0;
    endtask

    // wait a falling edge, then return inputs to idle
    task automatic next_cycle();
        @(negedge clk_i);
        drive_idle();
    endtask

    // valid and qualified cycle, conditions added by the caller
    task automatic next_qualified_cycle();
        next_cycle();
        valid_i = 1'b1;
        tc_qualified_i = 1'b1;
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_mark = err_count;
    endtask

    task automatic finish_test();
        next_cycle();
        #5;
        if (err_count == test_mark) begin
            pass_tests++;
            $display("test %s: ok", test_name);
        end else begin
            fail_tests++;
            $display("test %s: %0d mismatches", test_name, err_count - test_mark);
        end
    endtask

    initial begin
        rst_ni = 1'b0;
        drive_idle();
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;

        start_test("addr_compress");
        next_cycle();
        addr_to_compress_i = '0;
        next_cycle();
        addr_to_compress_i = '1;
        for (int i = 0; i < XLEN; i++) begin
            next_cycle();
            addr_to_compress_i = addr_t'(1) << i;
            next_cycle();
            addr_to_compress_i = ~(addr_t'(1) << i);
        end
        repeat (20) begin
            next_cycle();
            addr_to_compress_i = rand_word(32);
        end
        finish_test();

        start_test("support_precedence");
        next_cycle();
        valid_i = 1;
        tc_enc_enabled_i = 1;
        next_qualified_cycle();
        lc_exception_i = 1;
        tc_opmode_change_i = 1;
        // updiscon packet, then a support packet reports it
        next_qualified_cycle();
        lc_updiscon_i = 1;
        next_cycle();
        valid_i = 1;
        lc_final_qualified_i = 1;
        next_qualified_cycle();
        nc_qualified_i = 0;
        next_cycle();
        valid_i = 1;
        tc_enc_disabled_i = 1;
        finish_test();

        start_test("exception_sequence");
        // trap without address sets reported
        next_qualified_cycle();
        lc_exception_i = 1;
        tc_exception_i = 1;
        next_qualified_cycle();
        lc_exception_i = 1;
        next_qualified_cycle();
        lc_exception_i = 1;
        next_qualified_cycle();
        lc_updiscon_i = 1;
        tc_exception_i = 1;
        finish_test();

        start_test("start_resync");
        next_qualified_cycle();
        tc_first_qualified_i = 1;
        next_qualified_cycle();
        tc_privchange_i = 1;
        next_qualified_cycle();
        tc_gt_max_resync_i = 1;
        finish_test();

        start_test("diff_vs_addr");
        next_qualified_cycle();
        lc_updiscon_i = 1;
        next_qualified_cycle();
        lc_updiscon_i = 1;
        tc_branch_map_empty_i = 1;
        next_qualified_cycle();
        tc_et_max_resync_i = 1;
        next_qualified_cycle();
        tc_exception_i = 1;
        tc_retired_i = 1;
        tc_branch_map_empty_i = 1;
        next_qualified_cycle();
        nc_exception_i = 1;
        next_qualified_cycle();
        nc_privchange_i = 1;
        tc_branch_map_empty_i = 1;
        next_qualified_cycle();
        nc_qualified_i = 0;
        tc_branch_map_empty_i = 1;
        next_qualified_cycle();
        tc_branch_map_full_i = 1;
        next_qualified_cycle();
        // unqualified, then invalid
        next_cycle();
        valid_i = 1;
        lc_updiscon_i = 1;
        next_cycle();
        tc_enc_enabled_i = 1;
        tc_qualified_i = 1;
        lc_exception_i = 1;
        finish_test();

        start_test("random_run");
        repeat (RAND_CYCLES) begin
            next_cycle();
            valid_i = rand_bit() | rand_bit();
            tc_qualified_i = rand_bit() | rand_bit();
            nc_qualified_i = rand_bit() | rand_bit();
            // rare triggers, two draws ANDed
            tc_enc_enabled_i = rand_bit() & rand_bit();
            tc_enc_disabled_i = rand_bit() & rand_bit();
            tc_opmode_change_i = rand_bit() & rand_bit();
            lc_final_qualified_i = rand_bit() & rand_bit();
            lc_exception_i = rand_bit() & rand_bit();
            lc_updiscon_i = rand_bit() & rand_bit();
            tc_first_qualified_i = rand_bit() & rand_bit();
            tc_privchange_i = rand_bit() & rand_bit();
            tc_gt_max_resync_i = rand_bit() & rand_bit();
            tc_exception_i = rand_bit();
            tc_retired_i = rand_bit();
            tc_et_max_resync_i = rand_bit();
            tc_branch_map_empty_i = rand_bit();
            tc_branch_map_full_i = rand_bit();
            nc_exception_i = rand_bit();
            nc_privchange_i = rand_bit();
            nc_branch_map_empty_i = rand_bit();
            nc_retired_i = rand_bit();
            addr_to_compress_i = addr_t'($signed(rand_word(32)) >>> rand_word(5));
        end
        finish_test();

        if (DUT.i_checker.fail_cnt != 0) begin
            $display("%0d assertion failures in the bound checker", DUT.i_checker.fail_cnt);
        end
        $display("tests passed %0d, tests failed %0d, mismatches %0d",
                 pass_tests, fail_tests, err_count);
        if (fail_tests == 0 && err_count == 0 && DUT.i_checker.fail_cnt == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: bench/trdb_priority_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent assertions on the selector outputs
// bound into the packet-selection top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module trdb_priority_checker import trdb_pkg::*; (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   valid_o,
    input trdb_format_e           packet_format_o,
    input trdb_f_sync_subformat_e packet_f_sync_subformat_o,
    input logic                   thaddr_o,
    input logic                   lc_tc_mux_o,
    input logic                   resync_timer_rst_o,
    input keep_bits_t             keep_bits_o
);

    // failed assertion count, read by the testbench
    int fail_cnt = 0;

    // no side outputs without a packet
    idle_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !valid_o |-> (!thaddr_o && !lc_tc_mux_o && !resync_timer_rst_o))
        else begin
            $error("side outputs active without valid_o");
            fail_cnt++;
        end

    // trap address only on sync trap packets
    thaddr_trap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        thaddr_o |-> (packet_format_o == F_SYNC && packet_f_sync_subformat_o == SF_TRAP))
        else begin
            $error("thaddr_o outside a sync trap packet");
            fail_cnt++;
        end

    // resync timer restarts only with start or trap
    resync_sync: assert property (@(posedge clk_i) disable iff (!rst_ni)
        resync_timer_rst_o |-> (packet_format_o == F_SYNC
                                && (packet_f_sync_subformat_o == SF_START
                                    || packet_f_sync_subformat_o == SF_TRAP)))
        else begin
            $error("resync timer reset outside sync start or trap");
            fail_cnt++;
        end

    // kept bits always in 1..XLEN
    keep_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (keep_bits_o >= keep_bits_t'(1)) && (keep_bits_o <= keep_bits_t'(XLEN)))
        else begin
            $error("keep_bits_o out of range");
            fail_cnt++;
        end

endmodule

bind trdb_priority trdb_priority_checker i_checker (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .valid_o                   (valid_o),
    .packet_format_o           (packet_format_o),
    .packet_f_sync_subformat_o (packet_f_sync_subformat_o),
    .thaddr_o                  (thaddr_o),
    .lc_tc_mux_o               (lc_tc_mux_o),
    .resync_timer_rst_o        (resync_timer_rst_o),
    .keep_bits_o               (keep_bits_o)
);

// File: verilog/trdb_priority.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top of the packet-selection stage
// format selector plus address compressor
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module trdb_priority import trdb_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   valid_i,
    // last cycle conditions
    input  logic                   lc_exception_i,
    input  logic                   lc_updiscon_i,
    input  logic                   lc_final_qualified_i,
    // this cycle conditions
    input  logic                   tc_qualified_i,
    input  logic                   tc_exception_i,
    input  logic                   tc_retired_i,
    input  logic                   tc_first_qualified_i,
    input  logic                   tc_privchange_i,
    input  logic                   tc_gt_max_resync_i,
    input  logic                   tc_et_max_resync_i,
    input  logic                   tc_branch_map_empty_i,
    input  logic                   tc_branch_map_full_i,
    input  logic                   tc_enc_enabled_i,
    input  logic                   tc_enc_disabled_i,
    input  logic                   tc_opmode_change_i,
    // next cycle conditions
    input  logic                   nc_exception_i,
    input  logic                   nc_privchange_i,
    input  logic                   nc_branch_map_empty_i,
    input  logic                   nc_qualified_i,
    input  logic                   nc_retired_i,
    // address whose low bits get emitted
    input  addr_t                  addr_to_compress_i,
    // packet emitter side
    output logic                   valid_o,
    output trdb_format_e           packet_format_o,
    output trdb_f_sync_subformat_e packet_f_sync_subformat_o,
    output logic                   thaddr_o,
    output logic                   lc_tc_mux_o,
    output logic                   resync_timer_rst_o,
    output qual_status_e           qual_status_o,
    output keep_bits_t             keep_bits_o
);

    // format decision and history
    trdb_packet_select i_packet_select (
        .clk_i                     (clk_i),
        .rst_ni                    (rst_ni),
        .valid_i                   (valid_i),
        .lc_exception_i            (lc_exception_i),
        .lc_updiscon_i             (lc_updiscon_i),
        .lc_final_qualified_i      (lc_final_qualified_i),
        .tc_qualified_i            (tc_qualified_i),
        .tc_exception_i            (tc_exception_i),
        .tc_retired_i              (tc_retired_i),
        .tc_first_qualified_i      (tc_first_qualified_i),
        .tc_privchange_i           (tc_privchange_i),
        .tc_gt_max_resync_i        (tc_gt_max_resync_i),
        .tc_et_max_resync_i        (tc_et_max_resync_i),
        .tc_branch_map_empty_i     (tc_branch_map_empty_i),
        .tc_branch_map_full_i      (tc_branch_map_full_i),
        .tc_enc_enabled_i          (tc_enc_enabled_i),
        .tc_enc_disabled_i         (tc_enc_disabled_i),
        .tc_opmode_change_i        (tc_opmode_change_i),
        .nc_exception_i            (nc_exception_i),
        .nc_privchange_i           (nc_privchange_i),
        .nc_branch_map_empty_i     (nc_branch_map_empty_i),
        .nc_qualified_i            (nc_qualified_i),
        .nc_retired_i              (nc_retired_i),
        .valid_o                   (valid_o),
        .packet_format_o           (packet_format_o),
        .packet_f_sync_subformat_o (packet_f_sync_subformat_o),
        .thaddr_o                  (thaddr_o),
        .lc_tc_mux_o               (lc_tc_mux_o),
        .resync_timer_rst_o        (resync_timer_rst_o),
        .qual_status_o             (qual_status_o)
    );

    // kept address bits, independent of the packet choice
    trdb_addr_compress i_addr_compress (
        .addr_i      (addr_to_compress_i),
        .keep_bits_o (keep_bits_o)
    );

endmodule

// File: verilog/trdb_packet_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet format selection flowchart
// reported and ended-history registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module trdb_packet_select import trdb_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   valid_i,
    // last cycle
    input  logic                   lc_exception_i,
    input  logic                   lc_updiscon_i,
    input  logic                   lc_final_qualified_i,
    // this cycle
    input  logic                   tc_qualified_i,
    input  logic                   tc_exception_i,
    input  logic                   tc_retired_i,
    input  logic                   tc_first_qualified_i,
    input  logic                   tc_privchange_i,
    input  logic                   tc_gt_max_resync_i,
    input  logic                   tc_et_max_resync_i,
    input  logic                   tc_branch_map_empty_i,
    input  logic                   tc_branch_map_full_i,
    input  logic                   tc_enc_enabled_i,
    input  logic                   tc_enc_disabled_i,
    input  logic                   tc_opmode_change_i,
    // next cycle
    input  logic                   nc_exception_i,
    input  logic                   nc_privchange_i,
    input  logic                   nc_branch_map_empty_i,
    input  logic                   nc_qualified_i,
    input  logic                   nc_retired_i,
    // toward the packet emitter
    output logic                   valid_o,
    output trdb_format_e           packet_format_o,
    output trdb_f_sync_subformat_e packet_f_sync_subformat_o,
    output logic                   thaddr_o,
    output logic                   lc_tc_mux_o,
    output logic                   resync_timer_rst_o,
    output qual_status_e           qual_status_o
);

    // exception with no retirement this cycle
    logic tc_exc_only;
    // exception with retirement
    logic tc_er_n;
    // resync timer about to expire with branches pending
    logic tc_resync_br;
    // branch map needs reporting
    logic tc_rpt_br;
    logic nc_exc_only;
    // privilege change next cycle with branches pending
    logic nc_ppccd_br;
    // format 3 subformat 3 request
    logic support_trig;
    // diff-delta unless the branch map is empty
    trdb_format_e branch_fmt;

    // history registers
    logic reported_q;
    logic reported_d;
    logic reported_upd;
    logic ended_ntr_q;
    logic ended_ntr_d;
    logic ended_rep_q;
    logic ended_rep_d;

    assign tc_exc_only  = tc_exception_i && !tc_retired_i;
    assign tc_er_n      = tc_exception_i && tc_retired_i;
    assign tc_resync_br = tc_et_max_resync_i && !tc_branch_map_empty_i;
    assign tc_rpt_br    = tc_branch_map_full_i;
    assign nc_exc_only  = nc_exception_i && !nc_retired_i;
    assign nc_ppccd_br  = nc_privchange_i && !nc_branch_map_empty_i;
    assign support_trig = tc_enc_enabled_i || tc_enc_disabled_i || tc_opmode_change_i
                          || lc_final_qualified_i;
    assign branch_fmt   = tc_branch_map_empty_i ? F_ADDR_ONLY : F_DIFF_DELTA;

    // decision walk in priority order
    always_comb begin
        valid_o                   = 1'b0;
        packet_format_o           = F_OPT_EXT;
        packet_f_sync_subformat_o = SF_START;
        thaddr_o                  = 1'b0;
        lc_tc_mux_o               = 1'b0;
        resync_timer_rst_o        = 1'b0;
        qual_status_o             = NO_CHANGE;
        reported_d                = 1'b0;
        ended_ntr_d               = 1'b0;
        ended_rep_d               = 1'b0;

        if (valid_i) begin
            if (support_trig) begin
                // support packet wins over everything qualified
                valid_o                   = 1'b1;
                packet_format_o           = F_SYNC;
                packet_f_sync_subformat_o = SF_SUPPORT;
                // updiscon ending takes precedence
                if (ended_ntr_q) begin
                    qual_status_o = ENDED_NTR;
                end else if (ended_rep_q) begin
                    qual_status_o = ENDED_REP;
                end
            end else if (tc_qualified_i) begin
                if (lc_exception_i) begin
                    valid_o            = 1'b1;
                    packet_format_o    = F_SYNC;
                    resync_timer_rst_o = 1'b1;
                    if (tc_exc_only) begin
                        // trap without address, cause from last cycle
                        packet_f_sync_subformat_o = SF_TRAP;
                        reported_d                = 1'b1;
                    end else if (reported_q) begin
                        // trap already reported, restart instead
                        packet_f_sync_subformat_o = SF_START;
                    end else begin
                        packet_f_sync_subformat_o = SF_TRAP;
                        thaddr_o                  = 1'b1;
                    end
                end else if (tc_first_qualified_i || tc_privchange_i || tc_gt_max_resync_i) begin
                    valid_o                   = 1'b1;
                    packet_format_o           = F_SYNC;
                    packet_f_sync_subformat_o = SF_START;
                    resync_timer_rst_o        = 1'b1;
                end else if (lc_updiscon_i) begin
                    // packet closes on an uninferable discontinuity
                    valid_o     = 1'b1;
                    ended_ntr_d = 1'b1;
                    if (tc_exc_only) begin
                        // cause and tval from this cycle
                        packet_format_o           = F_SYNC;
                        packet_f_sync_subformat_o = SF_TRAP;
                        resync_timer_rst_o        = 1'b1;
                        lc_tc_mux_o               = 1'b1;
                    end else begin
                        packet_format_o = branch_fmt;
                    end
                end else if (tc_resync_br || tc_er_n) begin
                    valid_o         = 1'b1;
                    packet_format_o = branch_fmt;
                end else if (nc_exc_only || nc_ppccd_br || !nc_qualified_i) begin
                    valid_o         = 1'b1;
                    packet_format_o = branch_fmt;
                    // last qualified instruction before tracing stops
                    ended_rep_d     = !nc_qualified_i;
                end else if (tc_rpt_br) begin
                    valid_o         = 1'b1;
                    packet_format_o = F_DIFF_DELTA;
                end
            end
        end
    end

    // reported only follows traps without address and starts outside exc_only
    assign reported_upd = (packet_format_o == F_SYNC)
                          && (((packet_f_sync_subformat_o == SF_TRAP) && !thaddr_o)
                          || ((packet_f_sync_subformat_o == SF_START) && !tc_exc_only));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            reported_q  <= 1'b0;
            ended_ntr_q <= 1'b0;
            ended_rep_q <= 1'b0;
        end else begin
            if (reported_upd) begin
                reported_q <= reported_d;
            end
            // ended flags reload every cycle
            ended_ntr_q <= ended_ntr_d;
            ended_rep_q <= ended_rep_d;
        end
    end

endmodule

// File: verilog/trdb_addr_compress.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address compression, number of low bits to keep
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module trdb_addr_compress import trdb_pkg::*; (
    input  addr_t      addr_i,
    output keep_bits_t keep_bits_o
);

    // leading zeros and leading ones of the address
    lz_cnt_t lead_zeros;
    lz_cnt_t lead_ones;
    lz_cnt_t lead_run;
    logic    all_zeros;
    logic    all_ones;

    // zeros counted directly
    trdb_lzc #(
        .WIDTH (XLEN)
    ) i_lzc_zeros (
        .in_i    (addr_i),
        .cnt_o   (lead_zeros),
        .empty_o (all_zeros)
    );

    // ones counted as zeros of the inverse
    trdb_lzc #(
        .WIDTH (XLEN)
    ) i_lzc_ones (
        .in_i    (~addr_i),
        .cnt_o   (lead_ones),
        .empty_o (all_ones)
    );

    // longer run gives the better compression
    assign lead_run = (lead_zeros > lead_ones) ? lead_zeros : lead_ones;

    // one sign bit survives so the emitter side can sign extend back
    // all-equal address collapses to its single sign bit
    assign keep_bits_o = (all_zeros || all_ones) ? keep_bits_t'(1)
                                                 : keep_bits_t'(XLEN - int'(lead_run) + 1);

endmodule

// File: verilog/trdb_lzc.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// leading-zero counter with all-zero flag
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module trdb_lzc #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         in_i,
    // zeros above the highest set bit
    output logic [$clog2(WIDTH)-1:0] cnt_o,
    // input is all zeros, cnt_o then meaningless
    output logic                     empty_o
);

    // set once the first one from the top is seen
    logic found;

    // priority search starting at the msb
    always_comb begin
        cnt_o = '0;
        found = 1'b0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            // only the highest set bit counts
            if (!found && in_i[i]) begin
                cnt_o = ($clog2(WIDTH))'(WIDTH - 1 - i);
                found = 1'b1;
            end
        end
    end

    // no bit set anywhere
    assign empty_o = ~found;

endmodule

// File: verilog/trdb_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address width, width types and packet encodings
// shared by the trace packet-selection stage
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package trdb_pkg;

    // traced instruction address width
    localparam int XLEN = 32;
    // bits needed for a leading run count
    localparam int LZ_W = $clog2(XLEN);

    // full instruction address
    typedef logic [XLEN-1:0] addr_t;
    // leading identical bits
    typedef logic [LZ_W-1:0] lz_cnt_t;
    // kept low bits, one extra bit so XLEN fits
    typedef logic [LZ_W:0] keep_bits_t;

    // packet format field
    typedef enum logic [1:0] {
        F_OPT_EXT    = 2'h0,
        F_DIFF_DELTA = 2'h1,
        F_ADDR_ONLY  = 2'h2,
        F_SYNC       = 2'h3
    } trdb_format_e;

    // subformat of sync packets
    typedef enum logic [1:0] {
        SF_START   = 2'h0,
        SF_TRAP    = 2'h1,
        // context reports not supported here
        SF_CONTEXT = 2'h2,
        SF_SUPPORT = 2'h3
    } trdb_f_sync_subformat_e;

    // qualification status carried by support packets
    typedef enum logic [1:0] {
        NO_CHANGE  = 2'h0,
        ENDED_REP  = 2'h1,
        // legal encoding, nothing drives it
        TRACE_LOST = 2'h2,
        ENDED_NTR  = 2'h3
    } qual_status_e;

endpackage
